//--- quick_rs232.f
rtl/rs232_pkg.sv
rtl/rs232_rx.sv
rtl/rs232_tx.sv
rtl/rx_fifo.sv
rtl/quick_rs232.sv
tb/quick_rs232_asserts.sv
tb/quick_rs232_tb.sv

//--- tb/quick_rs232_tb.sv
// Testbench for quick_rs232 covering transmit, receive, error frames, flow control and idle transmit
// Inputs change and outputs are sampled on the falling clock edge
// Received bytes are compared in arrival order as the FIFO is drained
`timescale 1ns/1ns

module quick_rs232_tb;

    localparam int BL = rs232_pkg::BYTE_LEN;
    localparam int CPB = rs232_pkg::CLKS_PER_BIT;
    localparam int DEPTH = rs232_pkg::RX_FIFO_DEPTH;
    localparam int WAIT_LIMIT = 40 * CPB;          // Cycles for a few frames
    localparam bit HAS_PARITY = (rs232_pkg::PARITY_MODE != rs232_pkg::PARITY_NONE);
    localparam int FRAME_BITS = HAS_PARITY ? 11 : 10;

    logic clk = 1'b0;
    logic rst, rx, rts, rx_read, tx_transaction, tx_data_ready;
    logic [BL-1:0] tx_data;
    logic [BL-1:0] rx_data;
    logic tx, cts, rx_err, rx_byte_received, rx_empty, tx_data_copied, tx_busy;

    integer seed = 32'haf8c_c898;
    int errors = 0;
    int checks = 0;
    int tests = 0;
    int rcv_count = 0;
    int err_count = 0;
    int copied_count = 0;
    int busy_cycles = 0;
    int reads_allowed = 0;        // Pops the drain process may still do
    logic [BL-1:0] expected_q[$];

    quick_rs232 dut
    (
        .clk              (clk),
        .rst              (rst),
        .rx               (rx),
        .tx               (tx),
        .rts              (rts),
        .cts              (cts),
        .rx_read          (rx_read),
        .rx_err           (rx_err),
        .rx_data          (rx_data),
        .rx_byte_received (rx_byte_received),
        .rx_empty         (rx_empty),
        .tx_transaction   (tx_transaction),
        .tx_data          (tx_data),
        .tx_data_ready    (tx_data_ready),
        .tx_data_copied   (tx_data_copied),
        .tx_busy          (tx_busy)
    );

    always #50 clk = ~clk;

    //////////////////////////////
    // Reference and helpers
    //////////////////////////////

    // Bit that gives an even or odd count of ones over data and parity
    function automatic logic expected_parity(input logic [BL-1:0] b);
        int ones;
        int i;
        ones = 0;
        for (i = 0; i < BL; i++)
            ones += b[i];
        if (rs232_pkg::PARITY_MODE == rs232_pkg::PARITY_ODD)
            return (ones % 2) == 0;
        return (ones % 2) == 1;
    endfunction

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string what);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("ERROR at %0t ns: %0s, got %0h, expected %0h",
                     $time, what, actual, expected);
        end
    endtask

    task automatic timed_out(input string what);
        errors++;
        $display("Timed out at %0t ns while waiting for %0s", $time, what);
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests++;
        $display("Test %0s finished with %0d errors", name, errors - errors_before);
    endtask

    task automatic clear_counts();
        @(posedge clk);
        rcv_count = 0;
        err_count = 0;
        copied_count = 0;
        busy_cycles = 0;
    endtask

    // Pulse and cycle counters sampled on the falling edge
    always @(negedge clk)
    begin
        rcv_count    <= rcv_count + rx_byte_received;
        err_count    <= err_count + rx_err;
        copied_count <= copied_count + tx_data_copied;
        busy_cycles  <= busy_cycles + tx_busy;
    end

    // Drain the FIFO and compare each head with the next expected byte
    always @(negedge clk)
    begin
        rx_read = 1'b0;
        if (reads_allowed > 0 && rx_empty === 1'b0)
        begin
            if (expected_q.size() == 0)
            begin
                errors++;
                $display("A byte came out of the receive FIFO that was never expected");
            end
            else
                check(rx_data, expected_q.pop_front(), "rx_data order");
            rx_read = 1'b1;
            reads_allowed--;
        end
    end

    task automatic drive_bit(input logic v);
        rx = v;
        repeat (CPB) @(negedge clk);
    endtask

    // One frame on rx followed by one idle bit time
    task automatic send_frame(input logic [BL-1:0] b, input logic bad_parity,
                              input logic low_stop);
        int i;
        @(negedge clk);
        drive_bit(1'b0);
        for (i = 0; i < BL; i++)
            drive_bit(b[i]);
        if (HAS_PARITY)
            drive_bit(expected_parity(b) ^ bad_parity);
        drive_bit(!low_stop);
        drive_bit(1'b1);
    endtask

    task automatic request_tx(input logic [BL-1:0] b);
        int waited;
        @(negedge clk);
        tx_data = b;
        tx_transaction = 1'b1;
        tx_data_ready = 1'b1;
        waited = 0;
        do
        begin
            @(negedge clk);
            waited++;
        end
        while (tx_data_copied !== 1'b1 && waited < WAIT_LIMIT);
        if (tx_data_copied !== 1'b1)
            timed_out("tx_data_copied");
        tx_transaction = 1'b0;
        tx_data_ready = 1'b0;
    endtask

    // Mid-bit samples of one tx frame counted from the start bit edge
    task automatic capture_tx_frame(output logic start_bit, output logic [BL-1:0] data,
                                    output logic par_bit, output logic stop_bit);
        int waited;
        int i;
        waited = 0;
        while (tx !== 1'b0 && waited < WAIT_LIMIT)
        begin
            @(negedge clk);
            waited++;
        end
        if (tx !== 1'b0)
        begin
            timed_out("a start bit on tx");
            {start_bit, data, par_bit, stop_bit} = 'x;
            return;
        end
        repeat (rs232_pkg::HALF_BIT) @(negedge clk);
        start_bit = tx;
        for (i = 0; i < BL; i++)
        begin
            repeat (CPB) @(negedge clk);
            data[i] = tx;
        end
        par_bit = 1'b0;
        if (HAS_PARITY)
        begin
            repeat (CPB) @(negedge clk);
            par_bit = tx;
        end
        repeat (CPB) @(negedge clk);
        stop_bit = tx;
    endtask

    task automatic wait_tx_idle();
        int waited;
        waited = 0;
        while (tx_busy !== 1'b0 && waited < WAIT_LIMIT)
        begin
            @(negedge clk);
            waited++;
        end
        if (tx_busy !== 1'b0)
            timed_out("tx_busy to fall");
    endtask

    task automatic wait_fifo_drained();
        int waited;
        waited = 0;
        while ((expected_q.size() != 0 || rx_empty !== 1'b1) && waited < WAIT_LIMIT)
        begin
            @(negedge clk);
            waited++;
        end
        if (expected_q.size() != 0 || rx_empty !== 1'b1)
            timed_out("the receive FIFO to deliver all bytes");
    endtask

    //////////////////////////////
    // Test sequence
    //////////////////////////////

    initial
    begin
        int n;
        int mark;
        int bad;
        int waited;
        int bad_cycles;
        logic [BL-1:0] value;
        logic [BL-1:0] d_bits;
        logic s_bit, p_bit, e_bit;

        rst = 1'b1;
        rx = 1'b1;
        rts = 1'b1;
        rx_read = 1'b0;
        tx_transaction = 1'b0;
        tx_data_ready = 1'b0;
        tx_data = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        mark = errors;
        check(tx, 1'b1, "tx in reset");
        check(cts, 1'b0, "cts in reset");
        check(tx_busy, 1'b0, "tx_busy in reset");
        check(tx_data_copied, 1'b0, "tx_data_copied in reset");
        check(rx_byte_received, 1'b0, "rx_byte_received in reset");
        check(rx_err, 1'b0, "rx_err in reset");
        check(rx_empty, 1'b1, "rx_empty in reset");
        rst = 1'b0;
        finish_test("reset", mark);

        // Transmit
        mark = errors;
        clear_counts();
        for (n = 0; n < 20; n++)
        begin
            value = BL'($random(seed));
            fork
                request_tx(value);
                capture_tx_frame(s_bit, d_bits, p_bit, e_bit);
            join
            check(s_bit, 1'b0, "tx start bit");
            check(d_bits, value, "tx data bits");
            if (HAS_PARITY)
                check(p_bit, expected_parity(value), "tx parity bit");
            check(e_bit, 1'b1, "tx stop bit");
            wait_tx_idle();
        end
        check(copied_count, 20, "tx_data_copied pulses");
        check(busy_cycles, 20 * FRAME_BITS * CPB, "tx_busy cycles over all frames");
        finish_test("transmit", mark);

        // Receive with the FIFO drained
        mark = errors;
        clear_counts();
        reads_allowed = 1000;
        for (n = 0; n < 20; n++)
        begin
            value = BL'($random(seed));
            expected_q.push_back(value);
            send_frame(value, 1'b0, 1'b0);
        end
        wait_fifo_drained();
        check(rcv_count, 20, "rx_byte_received pulses");
        check(err_count, 0, "rx_err pulses on good frames");
        finish_test("receive", mark);

        // Error frames
        mark = errors;
        clear_counts();
        reads_allowed = 0;
        bad = 0;
        if (HAS_PARITY)
        begin
            send_frame(BL'($random(seed)), 1'b1, 1'b0);
            bad++;
            check(rx_empty, 1'b1, "rx_empty after bad parity");
        end
        send_frame(BL'($random(seed)), 1'b0, 1'b1);
        bad++;
        check(rx_empty, 1'b1, "rx_empty after low stop bit");
        check(err_count, bad, "rx_err pulses on bad frames");
        @(posedge clk);
        reads_allowed = 1000;
        value = BL'($random(seed));
        expected_q.push_back(value);
        send_frame(value, 1'b0, 1'b0);
        wait_fifo_drained();
        check(rcv_count, 1, "good frame after bad ones");
        finish_test("error frames", mark);

        // Flow control with the FIFO filled and no reads
        mark = errors;
        clear_counts();
        reads_allowed = 0;
        @(negedge clk);
        rts = 1'b0;
        @(negedge clk);
        check(cts, 1'b0, "cts with rts low");
        rts = 1'b1;
        @(negedge clk);
        check(cts, 1'b1, "cts with rts high and room in the FIFO");
        for (n = 0; n < DEPTH; n++)
        begin
            value = BL'($random(seed));
            expected_q.push_back(value);
            send_frame(value, 1'b0, 1'b0);
        end
        check(cts, 1'b0, "cts with the FIFO full");
        send_frame(BL'($random(seed)), 1'b0, 1'b0);    // Peer ignores cts and overruns the FIFO
        check(err_count, 1, "rx_err on overrun");
        check(rcv_count, DEPTH, "bytes stored before overrun");
        @(posedge clk);
        reads_allowed = 1;
        waited = 0;
        while (cts !== 1'b1 && waited < WAIT_LIMIT)
        begin
            @(negedge clk);
            waited++;
        end
        if (cts !== 1'b1)
            timed_out("cts to rise after one rx_read");
        @(posedge clk);
        reads_allowed = 1000;
        wait_fifo_drained();
        finish_test("flow control", mark);

        // Data ready without a transaction
        mark = errors;
        clear_counts();
        @(negedge clk);
        tx_data = BL'($random(seed));
        tx_data_ready = 1'b1;
        bad_cycles = 0;
        repeat (4 * CPB)
        begin
            @(negedge clk);
            if (tx !== 1'b1 || tx_busy !== 1'b0 || tx_data_copied !== 1'b0)
                bad_cycles++;
        end
        tx_data_ready = 1'b0;
        check(bad_cycles, 0, "cycles with tx activity and no transaction");
        check(copied_count, 0, "tx_data_copied with no transaction");
        finish_test("no transaction", mark);

        check(dut.u_asserts.failures, 0, "concurrent assertion failures");
        $display("Tests run: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

//--- tb/quick_rs232_asserts.sv
// Concurrent checks on the quick_rs232 ports and the receive FIFO full flag
// All checks are off while rst is high
// failures counts every failed check and is read by the testbench at the end
`timescale 1ns/1ns

module quick_rs232_asserts
(
    input logic clk,
    input logic rst,
    input logic tx,
    input logic tx_busy,
    input logic tx_data_copied,
    input logic rx_byte_received,
    input logic rx_err,
    input logic cts,
    input logic fifo_full
);

    int failures = 0;

    // Line idles high between frames
    idle_line_high: assert property (@(posedge clk) disable iff (rst) !tx_busy |-> tx)
        else begin failures++; $error("tx low while tx_busy is low"); end

    // A frame ends either good or bad, never both
    rx_result_unique: assert property (@(posedge clk) disable iff (rst)
                                       !(rx_byte_received && rx_err))
        else begin failures++; $error("rx_byte_received and rx_err high together"); end

    copied_one_cycle: assert property (@(posedge clk) disable iff (rst)
                                       tx_data_copied |=> !tx_data_copied)
        else begin failures++; $error("tx_data_copied longer than one cycle"); end

    cts_drops_on_full: assert property (@(posedge clk) disable iff (rst) fifo_full |=> !cts)
        else begin failures++; $error("cts still high after fifo_full"); end

endmodule

bind quick_rs232 quick_rs232_asserts u_asserts
(
    .clk              (clk),
    .rst              (rst),
    .tx               (tx),
    .tx_busy          (tx_busy),
    .tx_data_copied   (tx_data_copied),
    .rx_byte_received (rx_byte_received),
    .rx_err           (rx_err),
    .cts              (cts),
    .fifo_full        (fifo_full)
);

//--- rtl/quick_rs232.sv
// Full-duplex RS-232 port with a receive FIFO and RTS/CTS on the receive side
// Frame format and bit time come from the shared package
// rx and rts are used as is and must be synchronous to clk
`timescale 1ns/1ns

module quick_rs232
(
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              rx,
    output logic                              tx,
    input  logic                              rts,
    output logic                              cts,
    input  logic                              rx_read,
    output logic                              rx_err,
    output logic [rs232_pkg::BYTE_LEN-1:0]    rx_data,
    output logic                              rx_byte_received,
    output logic                              rx_empty,
    input  logic                              tx_transaction,
    input  logic [rs232_pkg::BYTE_LEN-1:0]    tx_data,
    input  logic                              tx_data_ready,
    output logic                              tx_data_copied,
    output logic                              tx_busy
);

    logic                            rx_push;
    logic [rs232_pkg::BYTE_LEN-1:0]  rx_push_data;
    logic                            fifo_full;

    //////////////////////////////
    // Receive path
    //////////////////////////////

    rs232_rx u_rx
    (
        .clk              (clk),
        .rst              (rst),
        .rx               (rx),
        .rts              (rts),
        .fifo_full        (fifo_full),
        .rx_push          (rx_push),
        .rx_push_data     (rx_push_data),
        .rx_err           (rx_err),
        .rx_byte_received (rx_byte_received),
        .cts              (cts)
    );

    rx_fifo u_fifo
    (
        .clk       (clk),
        .rst       (rst),
        .push      (rx_push),
        .push_data (rx_push_data),
        .pop       (rx_read),
        .pop_data  (rx_data),
        .full      (fifo_full),
        .empty     (rx_empty)
    );

    //////////////////////////////
    // Transmit path
    //////////////////////////////

    rs232_tx u_tx
    (
        .clk            (clk),
        .rst            (rst),
        .tx_transaction (tx_transaction),
        .tx_data_ready  (tx_data_ready),
        .tx_data        (tx_data),
        .tx             (tx),
        .tx_data_copied (tx_data_copied),
        .tx_busy        (tx_busy)
    );

endmodule

//--- rtl/rx_fifo.sv
// Synchronous FIFO for received bytes
// pop_data shows the head entry and is valid only while empty is low
// A push while full and a pop while empty are ignored
`timescale 1ns/1ns

module rx_fifo
(
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              push,
    input  logic [rs232_pkg::BYTE_LEN-1:0]    push_data,
    input  logic                              pop,
    output logic [rs232_pkg::BYTE_LEN-1:0]    pop_data,
    output logic                              full,
    output logic                              empty
);

    localparam int DEPTH = rs232_pkg::RX_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = PTR_W + 1;

    logic [rs232_pkg::BYTE_LEN-1:0]  mem [DEPTH];
    logic [PTR_W-1:0]                wr_ptr;
    logic [PTR_W-1:0]                rd_ptr;
    logic [CNT_W-1:0]                count;
    logic                            do_push;
    logic                            do_pop;

    // Wrap explicitly so any depth works
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign full     = (count == CNT_W'(DEPTH));
    assign empty    = (count == '0);
    assign pop_data = mem[rd_ptr];

    always_ff @(posedge clk)
    begin
        if (do_push)
            mem[wr_ptr] <= push_data;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= next_ptr(wr_ptr);
            if (do_pop)
                rd_ptr <= next_ptr(rd_ptr);
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;      // Both or neither
            endcase
        end
    end

endmodule

//--- rtl/rs232_tx.sv
// RS-232 transmitter, 8 data bits LSB first, optional parity, one stop bit
// A byte is taken in idle while tx_transaction and tx_data_ready are both high
// A request held high is taken again in the first idle cycle after the stop bit
// tx_data_ready is ignored while a frame is in flight
`timescale 1ns/1ns

module rs232_tx
(
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              tx_transaction,
    input  logic                              tx_data_ready,
    input  logic [rs232_pkg::BYTE_LEN-1:0]    tx_data,
    output logic                              tx,
    output logic                              tx_data_copied,
    output logic                              tx_busy
);

    localparam int CNT_W = rs232_pkg::BIT_CNT_W;
    localparam int IDX_W = $clog2(rs232_pkg::BYTE_LEN);

    localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(rs232_pkg::CLKS_PER_BIT - 1);
    localparam logic [IDX_W-1:0] IDX_LAST = IDX_W'(rs232_pkg::BYTE_LEN - 1);

    localparam logic [2:0] ST_IDLE   = 3'd0;
    localparam logic [2:0] ST_START  = 3'd1;
    localparam logic [2:0] ST_DATA   = 3'd2;
    localparam logic [2:0] ST_PARITY = 3'd3;
    localparam logic [2:0] ST_STOP   = 3'd4;

    logic [2:0]                      state;
    logic [CNT_W-1:0]                cnt;
    logic [IDX_W-1:0]                bit_idx;
    logic [rs232_pkg::BYTE_LEN-1:0]  tx_buf;
    logic                            accept;
    logic                            bit_done;
    logic                            parity_bit;

    assign accept   = (state == ST_IDLE) && tx_transaction && tx_data_ready;
    assign bit_done = (cnt == BIT_LAST);

    // Even parity is the XOR of the byte, odd parity its inverse
    assign parity_bit = (^tx_buf) ^ (rs232_pkg::PARITY_MODE == rs232_pkg::PARITY_ODD);

    always_ff @(posedge clk)
    begin
        if (accept)
            tx_buf <= tx_data;
    end

    //////////////////////////////
    // Serialiser FSM
    //////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state          <= ST_IDLE;
            cnt            <= '0;
            bit_idx        <= '0;
            tx             <= 1'b1;    // Line idles high
            tx_data_copied <= 1'b0;
            tx_busy        <= 1'b0;
        end
        else
        begin
            tx_data_copied <= 1'b0;
            cnt            <= cnt + 1'b1;
            case (state)
                ST_IDLE:
                begin
                    cnt <= '0;
                    if (accept)
                    begin
                        tx             <= 1'b0;   // Start bit from this edge
                        tx_data_copied <= 1'b1;
                        tx_busy        <= 1'b1;
                        state          <= ST_START;
                    end
                end
                ST_START:
                begin
                    if (bit_done)
                    begin
                        cnt     <= '0;
                        bit_idx <= '0;
                        tx      <= tx_buf[0];
                        state   <= ST_DATA;
                    end
                end
                ST_DATA:
                begin
                    if (bit_done)
                    begin
                        cnt     <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx != IDX_LAST)
                            tx <= tx_buf[bit_idx + 1'b1];
                        else if (rs232_pkg::PARITY_MODE == rs232_pkg::PARITY_NONE)
                        begin
                            tx    <= 1'b1;
                            state <= ST_STOP;
                        end
                        else
                        begin
                            tx    <= parity_bit;
                            state <= ST_PARITY;
                        end
                    end
                end
                ST_PARITY:
                begin
                    if (bit_done)
                    begin
                        cnt   <= '0;
                        tx    <= 1'b1;
                        state <= ST_STOP;
                    end
                end
                ST_STOP:
                begin
                    if (bit_done)
                    begin
                        tx_busy <= 1'b0;
                        state   <= ST_IDLE;
                    end
                end
                default:
                begin
                    tx    <= 1'b1;
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

//--- rtl/rs232_rx.sv
// RS-232 receiver, 8 data bits, optional parity, one stop bit
// rx is sampled directly, so it must already be synchronous to clk
// A frame with bad parity, a low stop bit or a full FIFO is dropped with rx_err
// cts is registered and lags rts and fifo_full by one cycle
`timescale 1ns/1ns

module rs232_rx
(
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              rx,
    input  logic                              rts,
    input  logic                              fifo_full,
    output logic                              rx_push,
    output logic [rs232_pkg::BYTE_LEN-1:0]    rx_push_data,
    output logic                              rx_err,
    output logic                              rx_byte_received,
    output logic                              cts
);

    localparam int CNT_W = rs232_pkg::BIT_CNT_W;
    localparam int IDX_W = $clog2(rs232_pkg::BYTE_LEN);

    localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(rs232_pkg::HALF_BIT - 1);
    localparam logic [CNT_W-1:0] BIT_LAST  = CNT_W'(rs232_pkg::CLKS_PER_BIT - 1);
    localparam logic [IDX_W-1:0] IDX_LAST  = IDX_W'(rs232_pkg::BYTE_LEN - 1);

    localparam logic [2:0] ST_HUNT   = 3'd0;
    localparam logic [2:0] ST_START  = 3'd1;
    localparam logic [2:0] ST_DATA   = 3'd2;
    localparam logic [2:0] ST_PARITY = 3'd3;
    localparam logic [2:0] ST_STOP   = 3'd4;
    localparam logic [2:0] ST_WAIT   = 3'd5;   // Stop sampled, wait for line high

    logic [2:0]                      state;
    logic [CNT_W-1:0]                cnt;
    logic [IDX_W-1:0]                bit_idx;
    logic                            par_acc;   // XOR of data and parity bits so far
    logic                            push_q;
    logic                            err_q;
    logic                            half_done;
    logic                            bit_done;
    logic                            parity_ok;
    logic [rs232_pkg::BYTE_LEN-1:0]  shreg;

    assign half_done = (cnt == HALF_LAST);
    assign bit_done  = (cnt == BIT_LAST);

    // Even parity leaves an even count of ones, odd parity an odd count
    assign parity_ok = (rs232_pkg::PARITY_MODE == rs232_pkg::PARITY_NONE) ||
                       (par_acc == (rs232_pkg::PARITY_MODE == rs232_pkg::PARITY_ODD));

    //////////////////////////////
    // Frame FSM
    //////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state   <= ST_HUNT;
            cnt     <= '0;
            bit_idx <= '0;
            par_acc <= 1'b0;
            push_q  <= 1'b0;
            err_q   <= 1'b0;
        end
        else
        begin
            push_q <= 1'b0;
            err_q  <= 1'b0;
            cnt    <= cnt + 1'b1;
            case (state)
                ST_HUNT:
                begin
                    cnt <= '0;
                    if (!rx)
                        state <= ST_START;
                end
                ST_START:
                begin
                    if (half_done)
                    begin
                        cnt     <= '0;
                        bit_idx <= '0;
                        par_acc <= 1'b0;
                        state   <= rx ? ST_HUNT : ST_DATA;   // Glitch, back to hunting
                    end
                end
                ST_DATA:
                begin
                    if (bit_done)
                    begin
                        cnt     <= '0;
                        par_acc <= par_acc ^ rx;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == IDX_LAST)
                        begin
                            if (rs232_pkg::PARITY_MODE == rs232_pkg::PARITY_NONE)
                                state <= ST_STOP;
                            else
                                state <= ST_PARITY;
                        end
                    end
                end
                ST_PARITY:
                begin
                    if (bit_done)
                    begin
                        cnt     <= '0;
                        par_acc <= par_acc ^ rx;
                        state   <= ST_STOP;
                    end
                end
                ST_STOP:
                begin
                    if (bit_done)
                    begin
                        cnt   <= '0;
                        state <= ST_WAIT;
                        // Bad stop, bad parity and overrun all end here
                        if (rx && parity_ok && !fifo_full)
                            push_q <= 1'b1;
                        else
                            err_q <= 1'b1;
                    end
                end
                ST_WAIT:
                begin
                    cnt <= '0;
                    if (rx)
                        state <= ST_HUNT;
                end
                default:
                begin
                    state <= ST_HUNT;
                end
            endcase
        end
    end

    // Data shift register, LSB arrives first
    always_ff @(posedge clk)
    begin
        if (state == ST_DATA && bit_done)
            shreg <= {rx, shreg[rs232_pkg::BYTE_LEN-1:1]};
    end

    // Clear to send only while the peer asks and there is room
    always_ff @(posedge clk)
    begin
        if (rst)
            cts <= 1'b0;
        else if (rs232_pkg::FLOW_CONTROL_ON)
            cts <= rts && !fifo_full;
        else
            cts <= 1'b1;
    end

    assign rx_push          = push_q;
    assign rx_byte_received = push_q;
    assign rx_push_data     = shreg;
    assign rx_err           = err_q;

endmodule

//--- rtl/rs232_pkg.sv
// Shared constants for the RS-232 port
// Frame format is fixed at build time: 8 data bits, one stop bit
// Parity may be none, even or odd; mark and space are not supported
// Bit time is a whole number of clk cycles with no runtime baud setting
package rs232_pkg;

    //////////////////////////////
    // Frame format
    //////////////////////////////

    localparam int BYTE_LEN = 8;                   // Data bits per frame

    localparam int CLKS_PER_BIT = 16;              // clk cycles per bit time
    localparam int HALF_BIT = CLKS_PER_BIT / 2;    // Sample point from a start edge

    // Cycle counter must hold CLKS_PER_BIT itself
    localparam int BIT_CNT_W = $clog2(CLKS_PER_BIT + 1);

    //////////////////////////////
    // Parity
    //////////////////////////////

    localparam logic [1:0] PARITY_NONE = 2'd0;
    localparam logic [1:0] PARITY_EVEN = 2'd1;     // Even count of ones incl. parity bit
    localparam logic [1:0] PARITY_ODD  = 2'd2;     // Odd count of ones incl. parity bit

    localparam logic [1:0] PARITY_MODE = PARITY_EVEN;

    //////////////////////////////
    // Receive side
    //////////////////////////////

    // When clear, cts stays high and rts has no effect
    localparam logic FLOW_CONTROL_ON = 1'b1;

    // Received bytes held until read
    localparam int RX_FIFO_DEPTH = 16;

endpackage
